//--- tb.f
mat_inv_pkg.sv
mat_inv_step_cnt.sv
mat_row_store.sv
mat_inv_ctrl.sv
mat_inv_top.sv
mat_inv_checker.sv
tb_mat_inv.sv

//--- Bender.yml
package:
  name: mat_inv

sources:
  - mat_inv_pkg.sv
  - mat_inv_step_cnt.sv
  - mat_row_store.sv
  - mat_inv_ctrl.sv
  - mat_inv_top.sv
  - target: test
    files:
      - mat_inv_checker.sv
      - tb_mat_inv.sv

//--- tb_mat_inv.sv
`timescale 1ns/1ps

module tb_mat_inv;

	import mat_inv_pkg::*;

	localparam int NUM_TESTS  = 7;
	localparam int READ_WORDS = LOAD_WORDS + MAT_N;
	localparam int DONE_EDGES = 21;
	localparam int MAX_CYCLES = NUM_TESTS * 80 + 100;

	logic              clk = 1'b0;
	logic              reset;
	logic              start_i;
	logic              data_valid_i;
	elem_t             data_i;
	logic [ADDR_W-1:0] rd_addr_i;
	elem_t             rd_data_o;
	logic              busy_o;
	logic              done_o;
	logic              singular_o;

	// Test table
	string test_name [NUM_TESTS];
	elem_t test_mat  [NUM_TESTS][LOAD_WORDS];
	bit    test_gap  [NUM_TESTS];
	bit    test_sing [NUM_TESTS];

	// Reference model results
	elem_t model_left  [MAT_N][MAT_N];
	elem_t model_right [MAT_N][MAT_N];
	elem_t exp_word    [READ_WORDS];
	bit    model_sing;

	elem_t rand_state;
	int    cycle_count = 0;

	//////////////////////////////
	// Clock, DUT, timeout
	//////////////////////////////

	always #50 clk = ~clk;

	mat_inv_top u_dut (
		.clk          (clk),
		.reset        (reset),
		.start_i      (start_i),
		.data_valid_i (data_valid_i),
		.data_i       (data_i),
		.rd_addr_i    (rd_addr_i),
		.rd_data_o    (rd_data_o),
		.busy_o       (busy_o),
		.done_o       (done_o),
		.singular_o   (singular_o)
	);

	always @(posedge clk)
	begin
		cycle_count++;
		assert (u_dut.u_checker.fail_count == 0)
		else
		begin
			$display("A bound control assertion failed");
			halt_on_error();
		end
		if (cycle_count >= MAX_CYCLES)
		begin
			$display("Timeout after %0d cycles, the run did not finish", cycle_count);
			$display("*** TEST FAILED ***");
			$fatal(1, "Simulation stopped by the cycle limit");
		end
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	task automatic halt_on_error();
		$display("*** TEST FAILED ***");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_value(input string test, input string what,
		input elem_t expected, input elem_t actual);
		assert (actual === expected)
		else
		begin
			$display("FAILED %s %s: expected %0h, actual %0h", test, what, expected, actual);
			halt_on_error();
		end
	endtask

	// LCG with the Numerical Recipes constants
	function automatic elem_t next_random();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	task automatic build_table();
		elem_t word;
		for (int i = 0; i < MAT_N; i++)
		begin
			for (int j = 0; j < MAT_N; j++)
			begin
				test_mat[0][i*MAT_N+j] = (i == j) ? elem_t'(1) : '0;
				test_mat[1][i*MAT_N+j] = (i == j) ? elem_t'(2 * i + 3) : '0;
			end
		end
		// Odd diagonal and even lower triangle keep every pivot odd
		test_mat[2] = '{
			3, 1, -2, 4, 7,
			2, 5, 1, -3, 2,
			-4, 6, 7, 1, -1,
			8, -2, 4, 9, 3,
			6, 4, -6, 2, 5
		};
		// Rows 0 and 1 equal
		test_mat[3] = '{
			2, 3, 1, 4, 5,
			2, 3, 1, 4, 5,
			1, 0, 6, 2, 3,
			7, 1, 2, 8, 4,
			3, 9, 1, 5, 2
		};
		for (int t = 4; t < 6; t++)
		begin
			for (int i = 0; i < MAT_N; i++)
			begin
				for (int j = 0; j < MAT_N; j++)
				begin
					word = next_random();
					if (i == j)
						word[0] = 1'b1;
					else if (i > j)
						word[0] = 1'b0;
					test_mat[t][i*MAT_N+j] = word;
				end
			end
		end
		test_mat[6] = test_mat[3];

		test_name = '{"identity", "diagonal", "general", "equal_rows",
			"random", "random_gaps", "equal_rows_gaps"};
		test_gap  = '{0, 0, 0, 0, 0, 1, 1};
		test_sing = '{0, 0, 0, 1, 0, 0, 1};
	endtask

	//////////////////////////////
	// Reference model
	//////////////////////////////

	// Fraction-free Gauss-Jordan on [A | I] with 32-bit wrap
	task automatic model_inverse(input int t);
		elem_t x;
		elem_t y;
		for (int i = 0; i < MAT_N; i++)
		begin
			for (int j = 0; j < MAT_N; j++)
			begin
				model_left[i][j]  = test_mat[t][i*MAT_N+j];
				model_right[i][j] = (i == j) ? elem_t'(1) : '0;
			end
		end
		for (int k = 0; k < MAT_N; k++)
		begin
			for (int r = 0; r < MAT_N; r++)
			begin
				if (r != k)
				begin
					x = model_left[k][k];
					y = model_left[r][k];
					for (int j = 0; j < MAT_N; j++)
					begin
						model_left[r][j]  = x * model_left[r][j] - y * model_left[k][j];
						model_right[r][j] = x * model_right[r][j] - y * model_right[k][j];
					end
				end
			end
		end
		model_sing = 1'b0;
		for (int i = 0; i < MAT_N; i++)
		begin
			for (int j = 0; j < MAT_N; j++)
			begin
				exp_word[i*MAT_N+j] = model_right[i][j];
			end
			exp_word[DIAG_BASE+i] = model_left[i][i];
			if (model_left[i][i] == '0)
				model_sing = 1'b1;
		end
	endtask

	//////////////////////////////
	// One table entry
	//////////////////////////////

	task automatic run_test(input int t);
		elem_t gap_draw;
		int    edges;
		model_inverse(t);
		check_value(test_name[t], "table singular flag", test_sing[t], model_sing);

		// Stray strobes while idle or done are dropped
		if (test_gap[t])
		begin
			for (int s = 0; s < 2; s++)
			begin
				@(negedge clk);
				data_valid_i = 1'b1;
				data_i       = next_random();
			end
		end
		@(negedge clk);
		data_valid_i = 1'b0;
		start_i      = 1'b1;
		@(negedge clk);
		start_i = 1'b0;
		check_value(test_name[t], "busy_o after start", 1, busy_o);
		check_value(test_name[t], "done_o after start", 0, done_o);

		// Serial row-major load
		for (int w = 0; w < LOAD_WORDS; w++)
		begin
			gap_draw = next_random();
			if (test_gap[t] && gap_draw[9])
			begin
				data_valid_i = 1'b0;
				@(negedge clk);
			end
			data_valid_i = 1'b1;
			data_i       = test_mat[t][w];
			@(negedge clk);
		end

		// Count edges after the one that took the last word
		data_valid_i = 1'b0;
		edges = 0;
		while (!done_o && edges < DONE_EDGES + 10)
		begin
			if (test_gap[t] && edges == 3)
			begin
				// Ignored start and extra word during ELIM
				start_i      = 1'b1;
				data_valid_i = 1'b1;
				data_i       = next_random();
			end
			else
			begin
				start_i      = 1'b0;
				data_valid_i = 1'b0;
			end
			@(negedge clk);
			edges++;
			if (!done_o)
				check_value(test_name[t], "busy_o during run", 1, busy_o);
		end
		start_i      = 1'b0;
		data_valid_i = 1'b0;
		assert (done_o)
		else
		begin
			$display("%s: done_o never rose after the last word", test_name[t]);
			halt_on_error();
		end
		check_value(test_name[t], "edges to done_o", DONE_EDGES, edges);
		check_value(test_name[t], "singular_o", test_sing[t], singular_o);
		check_value(test_name[t], "busy_o at done", 0, busy_o);

		// Readback with one cycle latency
		rd_addr_i = '0;
		for (int a = 0; a < READ_WORDS; a++)
		begin
			@(negedge clk);
			check_value(test_name[t], $sformatf("word %0d", a), exp_word[a], rd_data_o);
			rd_addr_i = ADDR_W'(a + 1);
		end
		check_value(test_name[t], "done_o held", 1, done_o);

		assert (u_dut.u_checker.fail_count == 0)
		else
		begin
			$display("%s: a bound control assertion failed", test_name[t]);
			halt_on_error();
		end
	endtask

	//////////////////////////////
	// Sequence
	//////////////////////////////

	initial
	begin
		reset        = 1'b0;
		start_i      = 1'b0;
		data_valid_i = 1'b0;
		data_i       = '0;
		rd_addr_i    = '0;
		rand_state   = 32'd34132;
		build_table();

		repeat (10) @(negedge clk);
		reset = 1'b1;
		@(negedge clk);
		check_value("after_reset", "busy_o", 0, busy_o);
		check_value("after_reset", "done_o", 0, done_o);
		check_value("after_reset", "singular_o", 0, singular_o);

		// Entries run back to back
		for (int t = 0; t < NUM_TESTS; t++)
			run_test(t);

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

//--- mat_inv_checker.sv
`timescale 1ns/1ps

module mat_inv_checker (
	input logic clk,
	input logic reset,
	input logic start_i,
	input logic busy_i,
	input logic done_i,
	input logic singular_i
);

	// Count of failed assertions
	int fail_count = 0;

	//////////////////////////////
	// Status outputs
	//////////////////////////////

	// Running and finished never overlap
	busy_done_excl: assert property (@(posedge clk) disable iff (!reset)
		!(busy_i && done_i))
	else
	begin
		$error("busy_o and done_o high together");
		fail_count++;
	end

	singular_with_done: assert property (@(posedge clk) disable iff (!reset)
		singular_i |-> done_i)
	else
	begin
		$error("singular_o high while done_o low");
		fail_count++;
	end

	// Accepted start clears done on the next cycle
	start_clears_done: assert property (@(posedge clk) disable iff (!reset)
		(start_i && !busy_i) |=> !done_i)
	else
	begin
		$error("done_o still high after an accepted start");
		fail_count++;
	end

endmodule

bind mat_inv_top mat_inv_checker u_checker (
	.clk        (clk),
	.reset      (reset),
	.start_i    (start_i),
	.busy_i     (busy_o),
	.done_i     (done_o),
	.singular_i (singular_o)
);

//--- mat_inv_top.sv
`timescale 1ns/1ps

module mat_inv_top (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           start_i,
	input  logic                           data_valid_i,
	input  mat_inv_pkg::elem_t             data_i,
	input  logic [mat_inv_pkg::ADDR_W-1:0] rd_addr_i,
	output mat_inv_pkg::elem_t             rd_data_o,
	output logic                           busy_o,
	output logic                           done_o,
	output logic                           singular_o
);

	import mat_inv_pkg::*;

	logic cnt_clear;
	logic cnt_step;
	logic load_last;
	logic elim_last;
	logic init;
	logic load_we;
	logic elim_we;
	logic singular;
	idx_t row_idx;
	idx_t col_idx;

	mat_inv_ctrl u_ctrl (
		.clk          (clk),
		.reset        (reset),
		.start_i      (start_i),
		.data_valid_i (data_valid_i),
		.load_last_i  (load_last),
		.elim_last_i  (elim_last),
		.singular_i   (singular),
		.cnt_clear_o  (cnt_clear),
		.cnt_step_o   (cnt_step),
		.init_o       (init),
		.load_we_o    (load_we),
		.elim_we_o    (elim_we),
		.busy_o       (busy_o),
		.done_o       (done_o),
		.singular_o   (singular_o)
	);

	// Load position, then pivot and target row
	mat_inv_step_cnt u_cnt (
		.clk         (clk),
		.reset       (reset),
		.clear_i     (cnt_clear),
		.step_i      (cnt_step),
		.row_idx_o   (row_idx),
		.col_idx_o   (col_idx),
		.load_last_o (load_last),
		.elim_last_o (elim_last)
	);

	mat_row_store u_store (
		.clk        (clk),
		.reset      (reset),
		.init_i     (init),
		.load_we_i  (load_we),
		.elim_we_i  (elim_we),
		.data_i     (data_i),
		.row_idx_i  (row_idx),
		.col_idx_i  (col_idx),
		.rd_addr_i  (rd_addr_i),
		.rd_data_o  (rd_data_o),
		.singular_o (singular)
	);

endmodule

//--- mat_inv_ctrl.sv
`timescale 1ns/1ps

module mat_inv_ctrl (
	input  logic clk,
	input  logic reset,
	input  logic start_i,
	input  logic data_valid_i,
	input  logic load_last_i,
	input  logic elim_last_i,
	input  logic singular_i,
	output logic cnt_clear_o,
	output logic cnt_step_o,
	output logic init_o,
	output logic load_we_o,
	output logic elim_we_o,
	output logic busy_o,
	output logic done_o,
	output logic singular_o
);

	import mat_inv_pkg::*;

	ctrl_state_t state_q;
	ctrl_state_t state_d;

	// Extra ELIM cycle after the last pair so the diagonal is final
	logic elim_tail;
	logic singular_q;
	logic start_ok;

	// Start only while neither running nor loading
	assign start_ok = start_i && ((state_q == IDLE) || (state_q == DONE));

	//////////////////////////////
	// Next state
	//////////////////////////////

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			IDLE, DONE:
			begin
				if (start_ok)
					state_d = LOAD;
			end
			LOAD:
			begin
				if (data_valid_i && load_last_i)
					state_d = ELIM;
			end
			ELIM:
			begin
				if (elim_tail)
					state_d = DONE;
			end
			default:
				state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			state_q    <= IDLE;
			elim_tail  <= 1'b0;
			singular_q <= 1'b0;
		end
		else
		begin
			state_q   <= state_d;
			elim_tail <= (state_q == ELIM) && !elim_tail && elim_last_i;
			if (start_ok)
				singular_q <= 1'b0;
			else if ((state_q == ELIM) && elim_tail)
				singular_q <= singular_i;
		end
	end

	//////////////////////////////
	// Outputs
	//////////////////////////////

	assign cnt_clear_o = start_ok;
	assign init_o      = start_ok;
	assign load_we_o   = (state_q == LOAD) && data_valid_i;
	assign elim_we_o   = (state_q == ELIM) && !elim_tail;
	assign cnt_step_o  = load_we_o || elim_we_o;
	assign busy_o      = (state_q == LOAD) || (state_q == ELIM);
	assign done_o      = (state_q == DONE);
	assign singular_o  = singular_q;

endmodule

//--- mat_row_store.sv
`timescale 1ns/1ps

module mat_row_store (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           init_i,
	input  logic                           load_we_i,
	input  logic                           elim_we_i,
	input  mat_inv_pkg::elem_t             data_i,
	input  mat_inv_pkg::idx_t              row_idx_i,
	input  mat_inv_pkg::idx_t              col_idx_i,
	input  logic [mat_inv_pkg::ADDR_W-1:0] rd_addr_i,
	output mat_inv_pkg::elem_t             rd_data_o,
	output logic                           singular_o
);

	import mat_inv_pkg::*;

	// Augmented matrix [A | I]
	elem_t left_half  [MAT_N][MAT_N];
	elem_t right_half [MAT_N][MAT_N];

	elem_t piv_x;
	elem_t row_y;
	elem_t rd_word;

	//////////////////////////////
	// Row update operands
	//////////////////////////////

	// Pivot element and the target row entry in the pivot column
	assign piv_x = left_half[col_idx_i][col_idx_i];
	assign row_y = left_half[row_idx_i][col_idx_i];

	//////////////////////////////
	// Load and elimination
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (init_i)
		begin
			for (int i = 0; i < MAT_N; i++)
			begin
				for (int j = 0; j < MAT_N; j++)
				begin
					right_half[i][j] <= (i == j) ? elem_t'(1) : '0;
				end
			end
		end

		if (load_we_i)
			left_half[row_idx_i][col_idx_i] <= data_i;

		if (elim_we_i)
		begin
			// Whole target row of both halves in one cycle, products wrap
			for (int j = 0; j < MAT_N; j++)
			begin
				left_half[row_idx_i][j] <= piv_x * left_half[row_idx_i][j]
					- row_y * left_half[col_idx_i][j];
				right_half[row_idx_i][j] <= piv_x * right_half[row_idx_i][j]
					- row_y * right_half[col_idx_i][j];
			end
		end
	end

	//////////////////////////////
	// Read port
	//////////////////////////////

	// Right half row-major, then the left diagonal
	always_comb
	begin
		rd_word = '0;
		for (int i = 0; i < MAT_N; i++)
		begin
			for (int j = 0; j < MAT_N; j++)
			begin
				if (rd_addr_i == ADDR_W'(i * MAT_N + j))
					rd_word = right_half[i][j];
			end
		end
		for (int d = 0; d < MAT_N; d++)
		begin
			if (rd_addr_i == ADDR_W'(DIAG_BASE + d))
				rd_word = left_half[d][d];
		end
	end

	always_ff @(posedge clk)
	begin
		if (!reset)
			rd_data_o <= '0;
		else
			rd_data_o <= rd_word;
	end

	//////////////////////////////
	// Singularity
	//////////////////////////////

	// Any zero on the left diagonal
	always_comb
	begin
		singular_o = 1'b0;
		for (int d = 0; d < MAT_N; d++)
		begin
			if (left_half[d][d] == '0)
				singular_o = 1'b1;
		end
	end

endmodule

//--- mat_inv_step_cnt.sv
`timescale 1ns/1ps

module mat_inv_step_cnt (
	input  logic              clk,
	input  logic              reset,
	input  logic              clear_i,
	input  logic              step_i,
	output mat_inv_pkg::idx_t row_idx_o,
	output mat_inv_pkg::idx_t col_idx_o,
	output logic              load_last_o,
	output logic              elim_last_o
);

	import mat_inv_pkg::*;

	localparam idx_t IDX_MAX = idx_t'(MAT_N - 1);

	logic elim_mode;
	idx_t row_q;
	idx_t col_q;
	idx_t last_row;
	logic row_end;

	assign row_idx_o = row_q;
	assign col_idx_o = col_q;

	// Last target row for the current pivot, pivot row is skipped
	assign last_row = (col_q == IDX_MAX) ? idx_t'(MAT_N - 2) : IDX_MAX;
	assign row_end  = (row_q == last_row);

	assign load_last_o = !elim_mode && (row_q == IDX_MAX) && (col_q == IDX_MAX);
	assign elim_last_o = elim_mode && (col_q == IDX_MAX) && row_end;

	always_ff @(posedge clk)
	begin
		if (!reset || clear_i)
		begin
			elim_mode <= 1'b0;
			row_q     <= '0;
			col_q     <= '0;
		end
		else if (step_i)
		begin
			if (!elim_mode)
			begin
				// Load walks row-major
				if (col_q == IDX_MAX)
				begin
					col_q <= '0;
					if (row_q == IDX_MAX)
					begin
						// First pair is pivot 0, row 1
						elim_mode <= 1'b1;
						row_q     <= idx_t'(1);
					end
					else
						row_q <= row_q + idx_t'(1);
				end
				else
					col_q <= col_q + idx_t'(1);
			end
			else if (!elim_last_o)
			begin
				if (row_end)
				begin
					col_q <= col_q + idx_t'(1);
					row_q <= '0;
				end
				else if (row_q + idx_t'(1) == col_q)
					row_q <= row_q + idx_t'(2);
				else
					row_q <= row_q + idx_t'(1);
			end
		end
	end

endmodule

//--- mat_inv_pkg.sv
package mat_inv_pkg;

	//////////////////////////////
	// Sizes
	//////////////////////////////

	// Matrix order
	localparam int MAT_N = 5;

	// Element width
	localparam int WORD_W = 32;

	// Row or column index width
	localparam int IDX_W = 3;

	// Read port address width
	localparam int ADDR_W = 5;

	// Words in one serial load
	localparam int LOAD_WORDS = MAT_N * MAT_N;

	// Read addresses from here on return the left diagonal
	localparam int DIAG_BASE = LOAD_WORDS;

	//////////////////////////////
	// Types
	//////////////////////////////

	typedef logic [WORD_W-1:0] elem_t;

	typedef logic [IDX_W-1:0] idx_t;

	typedef enum logic [1:0] {IDLE, LOAD, ELIM, DONE} ctrl_state_t;

endpackage
